// ==== bpc_engine.f ====
hw/bpc_geom_pkg.sv
hw/bpc_code_pkg.sv
hw/bpc_delta_collect.sv
hw/bpc_plane_xform.sv
hw/bpc_plane_coder.sv
hw/bpc_run_packer.sv
hw/bpc_engine.sv
verif/bpc_tb_clock.sv
verif/bpc_engine_properties.sv
verif/bpc_engine_tb.sv

// ==== Bender.yml ====
package:
  name: bpc_engine

sources:
  # packages first, then the design from the leaves up
  - hw/bpc_geom_pkg.sv
  - hw/bpc_code_pkg.sv
  - hw/bpc_delta_collect.sv
  - hw/bpc_plane_xform.sv
  - hw/bpc_plane_coder.sv
  - hw/bpc_run_packer.sv
  - hw/bpc_engine.sv

  - target: test
    files:
      - verif/bpc_tb_clock.sv
      - verif/bpc_engine_properties.sv
      - verif/bpc_engine_tb.sv

// ==== verif/bpc_engine_tb.sv ====
// testbench for bpc_engine
// reference model, directed tests, output monitor and timeout

module bpc_engine_tb
    import bpc_geom_pkg::*;
    import bpc_code_pkg::*;
();

    localparam int BLOCK_BEATS = 16;
    localparam int NWORDS      = WORDS_PER_BEAT * BLOCK_BEATS;
    localparam int NDELTA      = NWORDS - 1;
    localparam int N_BLOCKS    = 20;
    localparam int TIMEOUT     = N_BLOCKS * (BLOCK_BEATS + 16 + 8) * 4;
    localparam logic [31:0] SEED = 32'h02638d25;

    logic       clk;
    logic       rst_n;
    beat_t      beat_i;
    logic       valid_i;
    logic       ready_o;
    code_beat_t code_o;
    logic       valid_o;
    logic       ready_i;

    word_t             blk [NWORDS];
    word_t             dl [NDELTA];
    code_beat_t        exp_q [$];
    code_beat_t        mon_exp;
    logic [CODE_W-1:0] acc;
    int                asz;
    logic [31:0]       rng;
    logic [31:0]       bp_rng;
    logic              bp_en;
    logic              next_ready;
    int                cycles = 0;

    bpc_tb_clock #(
        .PERIOD       (8),
        .RESET_CYCLES (10)
    ) u_clock (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    bpc_engine #(
        .BLOCK_BEATS (BLOCK_BEATS)
    ) dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .beat_i  (beat_i),
        .valid_i (valid_i),
        .ready_o (ready_o),
        .code_o  (code_o),
        .valid_o (valid_o),
        .ready_i (ready_i)
    );

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x;
        y ^= y << 13;
        y ^= y >> 17;
        y ^= y << 5;
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic fail_now(string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(string sig, logic [CODE_W-1:0] exp_v, logic [CODE_W-1:0] act_v);
        fail_now($sformatf("[ERROR] %s expected 0x%0h got 0x%0h", sig, exp_v, act_v));
    endtask

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------
    // val holds w bits right aligned, placed after the bits already in acc
    function automatic void append_bits(logic [63:0] val, int w);
        acc |= CODE_W'(val) << (CODE_W - asz - w);
        asz += w;
    endfunction

    function automatic void append_plane(logic [NDELTA-1:0] x, logic [NDELTA-1:0] p);
        int n;
        int low;
        n   = 0;
        low = 0;
        for (int i = NDELTA - 1; i >= 0; i--) begin
            if (x[i]) begin
                n++;
                low = i;
            end
        end
        if (&x) begin
            append_bits(64'b00000, 5);
        end else if (p == '0) begin
            append_bits(64'b00001, 5);
        end else if (n == 2 && x[low+1]) begin
            append_bits({5'b00010, 6'(low)}, 11);
        end else if (n == 1) begin
            append_bits({5'b00011, 6'(low)}, 11);
        end else begin
            append_bits(64'(x) | (64'd1 << NDELTA), NDELTA + 1);
        end
    endfunction

    task automatic expect_block();
        logic [NDELTA-1:0] dbp [WORD_W];
        logic [NDELTA-1:0] dbx [WORD_W];
        word_t             d;
        int                run;
        bit                first;
        code_beat_t        w;
        for (int k = 0; k < NDELTA; k++) begin
            d = blk[k+1] - blk[k];
            for (int p = 0; p < WORD_W; p++) begin
                dbp[p][k] = d[p];
            end
        end
        dbx[WORD_W-1] = dbp[WORD_W-1];
        for (int p = 0; p < WORD_W - 1; p++) begin
            dbx[p] = dbp[p] ^ dbp[p+1];
        end
        run   = 0;
        first = 1'b1;
        for (int p = WORD_W - 1; p >= 0; p--) begin
            if (dbx[p] == '0) begin
                run++;
            end
            if (dbx[p] != '0 || p == 0) begin
                acc = '0;
                asz = 0;
                if (first) begin
                    append_bits({2'b00, blk[0]}, 18);
                end
                if (run == 1) begin
                    append_bits(3'b001, 3);
                end else if (run > 1) begin
                    append_bits({2'b01, 4'(run - 2)}, 6);
                end
                if (dbx[p] != '0) begin
                    append_plane(dbx[p], dbp[p]);
                end
                w.sop  = first;
                w.eop  = (p == 0);
                w.size = code_size_t'(asz);
                w.data = acc;
                exp_q.push_back(w);
                first = 1'b0;
                run   = 0;
            end
        end
    endtask

    // ------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------
    task automatic words_from_deltas(word_t base);
        blk[0] = base;
        for (int k = 0; k < NDELTA; k++) begin
            blk[k+1] = blk[k] + dl[k];
        end
    endtask

    task automatic clear_deltas();
        foreach (dl[k]) dl[k] = '0;
    endtask

    // ties bits 7/8 and 2/3/4 so zero planes and runs show up between raw planes
    task automatic random_deltas(word_t mask);
        word_t d;
        for (int k = 0; k < NDELTA; k++) begin
            d    = word_t'(next_rand()) & mask;
            d[7] = d[8];
            d[3] = d[4];
            d[2] = d[3];
            dl[k] = d;
        end
        words_from_deltas(word_t'(next_rand()));
    endtask

    // leaves valid_i high so the caller can stream the next block
    task automatic send_block();
        for (int b = 0; b < BLOCK_BEATS; b++) begin
            beat_i  = {blk[4*b], blk[4*b+1], blk[4*b+2], blk[4*b+3]};
            valid_i = 1'b1;
            while (!ready_o) begin
                @(posedge clk);
                #1;
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_block();
        expect_block();
        send_block();
        valid_i = 1'b0;
        wait_drain();
    endtask

    // ------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------
    task automatic identical_words_test();
        code_beat_t w;
        clear_deltas();
        words_from_deltas(16'h5a3c);
        // header then one run over all 16 planes, length coded as 14
        w.sop  = 1'b1;
        w.eop  = 1'b1;
        w.size = 7'd24;
        w.data = {2'b00, 16'h5a3c, 2'b01, 4'd14, 64'd0};
        exp_q.push_back(w);
        send_block();
        valid_i = 1'b0;
        wait_drain();
    endtask

    task automatic crafted_planes_test();
        word_t steps [2] = '{16'h0003, 16'h0a50};
        foreach (steps[s]) begin
            foreach (dl[k]) dl[k] = steps[s];
            words_from_deltas(16'h1234);
            run_block();
        end
        // lone one in plane 9, zero dbp with a non-zero dbx in plane 8
        clear_deltas();
        dl[20] = 16'h0200;
        words_from_deltas(16'hbeef);
        run_block();
        clear_deltas();
        dl[62] = 16'h0001;
        words_from_deltas(16'h0000);
        run_block();
        // adjacent pair in plane 4
        clear_deltas();
        dl[40] = 16'h0010;
        dl[41] = 16'h0010;
        words_from_deltas(16'hffff);
        run_block();
    endtask

    task automatic random_blocks_test();
        word_t masks [4] = '{16'hffff, 16'h0fff, 16'h00ff, 16'h3fff};
        foreach (masks[i]) begin
            random_deltas(masks[i]);
            run_block();
        end
    endtask

    task automatic backpressure_test();
        word_t saved [3][NWORDS];
        for (int i = 0; i < 3; i++) begin
            random_deltas(i == 1 ? 16'h0fff : 16'hffff);
            saved[i] = blk;
            run_block();
        end
        bp_en = 1'b1;
        for (int i = 0; i < 3; i++) begin
            blk = saved[i];
            run_block();
        end
        bp_en = 1'b0;
    endtask

    task automatic streaming_test();
        word_t masks [4] = '{16'h07ff, 16'hffff, 16'h001f, 16'h0fff};
        foreach (masks[i]) begin
            random_deltas(masks[i]);
            expect_block();
            send_block();
        end
        valid_i = 1'b0;
        wait_drain();
    endtask

    // ------------------------------------------------------------------
    // ready_i, output monitor, timeout
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        if (bp_en) begin
            bp_rng     = xorshift(bp_rng);
            next_ready = bp_rng[0];
        end else begin
            next_ready = 1'b1;
        end
        #1;
        ready_i = next_ready;
    end

    always @(posedge clk) begin
        if (rst_n && valid_o && ready_i) begin
            assert (exp_q.size() != 0)
                else fail_now("DUT sent an output word that no block accounts for");
            mon_exp = exp_q.pop_front();
            assert (code_o.sop == mon_exp.sop)
                else value_error("code_o.sop", mon_exp.sop, code_o.sop);
            assert (code_o.eop == mon_exp.eop)
                else value_error("code_o.eop", mon_exp.eop, code_o.eop);
            assert (code_o.size == mon_exp.size)
                else value_error("code_o.size", mon_exp.size, code_o.size);
            assert (code_o.data == mon_exp.data)
                else value_error("code_o.data", mon_exp.data, code_o.data);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            fail_now($sformatf("timeout, tests still running after %0d cycles", TIMEOUT));
        end
    end

    initial begin
        rng     = SEED;
        bp_rng  = xorshift(SEED);
        bp_en   = 1'b0;
        beat_i  = '0;
        valid_i = 1'b0;
        ready_i = 1'b1;
        @(posedge rst_n);
        @(posedge clk);
        #1;
        identical_words_test();
        crafted_planes_test();
        random_blocks_test();
        backpressure_test();
        streaming_test();
        // every block drained, so no word may be pending and intake must be open
        if (valid_o || !ready_o) begin
            fail_now("DUT still busy after the last expected output word");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

// ==== verif/bpc_engine_properties.sv ====
// output handshake and word format properties
// bound into bpc_run_packer

module bpc_engine_properties
    import bpc_code_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input code_beat_t code_i,
    input logic       valid_i,
    input logic       ready_i
);

    // a stalled word must not change or vanish
    assert property (@(posedge clk) disable iff (!rst_n)
        (valid_i && !ready_i) |=> (valid_i && $stable(code_i)))
        else $error("output word changed while stalled");

    assert property (@(posedge clk) disable iff (!rst_n)
        valid_i |-> (code_i.size <= CODE_W))
        else $error("output size larger than the data field");

    // bits past the size are zero
    assert property (@(posedge clk) disable iff (!rst_n)
        valid_i |-> ((code_i.data << code_i.size) == '0))
        else $error("output data has bits set below its size");

endmodule

bind bpc_run_packer bpc_engine_properties u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .code_i  (code_o),
    .valid_i (valid_o),
    .ready_i (ready_i)
);

// ==== verif/bpc_tb_clock.sv ====
// clock and reset generator for the testbench

module bpc_tb_clock #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // release just after an edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule

// ==== hw/bpc_engine.sv ====
// bpc_engine top level
// delta collector -> plane transform -> run packer

module bpc_engine
    import bpc_geom_pkg::*;
    import bpc_code_pkg::*;
#(
    parameter int BLOCK_BEATS = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  beat_t      beat_i,
    input  logic       valid_i,
    output logic       ready_o,
    output code_beat_t code_o,
    output logic       valid_o,
    input  logic       ready_i
);

    localparam int NDELTA = WORDS_PER_BEAT * BLOCK_BEATS - 1;

    logic                          block_valid;
    logic                          block_ready;
    word_t                         blk_base;
    word_t [NDELTA-1:0]            deltas;
    logic                          planes_valid;
    logic                          plane_release;
    word_t                         plane_base;
    logic [WORD_W-1:0][NDELTA-1:0] dbp;
    logic [WORD_W-1:0][NDELTA-1:0] dbx;

    bpc_delta_collect #(
        .BLOCK_BEATS (BLOCK_BEATS)
    ) u_collect (
        .clk           (clk),
        .rst_n         (rst_n),
        .beat_i        (beat_i),
        .valid_i       (valid_i),
        .ready_o       (ready_o),
        .block_valid_o (block_valid),
        .block_ready_i (block_ready),
        .base_o        (blk_base),
        .deltas_o      (deltas)
    );

    bpc_plane_xform #(
        .BLOCK_BEATS (BLOCK_BEATS)
    ) u_xform (
        .clk            (clk),
        .rst_n          (rst_n),
        .block_valid_i  (block_valid),
        .block_ready_o  (block_ready),
        .base_i         (blk_base),
        .deltas_i       (deltas),
        .planes_valid_o (planes_valid),
        .release_i      (plane_release),
        .base_o         (plane_base),
        .dbp_o          (dbp),
        .dbx_o          (dbx)
    );

    bpc_run_packer #(
        .BLOCK_BEATS (BLOCK_BEATS)
    ) u_packer (
        .clk            (clk),
        .rst_n          (rst_n),
        .planes_valid_i (planes_valid),
        .release_o      (plane_release),
        .base_i         (plane_base),
        .dbp_i          (dbp),
        .dbx_i          (dbx),
        .code_o         (code_o),
        .valid_o        (valid_o),
        .ready_i        (ready_i)
    );

endmodule

// ==== hw/bpc_run_packer.sv ====
// bpc_run_packer
// steps through the planes msb first, merges zero-plane runs
// and builds the sized output words with sop/eop framing

module bpc_run_packer
    import bpc_geom_pkg::*;
    import bpc_code_pkg::*;
#(
    parameter int BLOCK_BEATS = 16,
    localparam int NDELTA = WORDS_PER_BEAT * BLOCK_BEATS - 1
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          planes_valid_i,
    output logic                          release_o,
    input  word_t                         base_i,
    input  logic [WORD_W-1:0][NDELTA-1:0] dbp_i,
    input  logic [WORD_W-1:0][NDELTA-1:0] dbx_i,
    output code_beat_t                    code_o,
    output logic                          valid_o,
    input  logic                          ready_i
);

    typedef enum logic {PACK_IDLE, PACK_PLANES} pack_state_e;

    pack_state_e state_q;
    plane_idx_t  idx_q;
    logic [4:0]  run_q;
    logic [4:0]  run_len;
    logic        first_q;
    logic        step;
    logic        last_plane;
    logic        is_zero;
    logic        emit;
    symbol_t     sym;
    code_beat_t  word_d;

    // drop a left-aligned field in at bit offset at
    function automatic logic [CODE_W-1:0] place(logic [63:0] field, code_size_t at);
        return {field, {(CODE_W - 64){1'b0}}} >> at;
    endfunction

    bpc_plane_coder #(
        .BLOCK_BEATS (BLOCK_BEATS)
    ) u_coder (
        .dbx_i (dbx_i[idx_q]),
        .dbp_i (dbp_i[idx_q]),
        .sym_o (sym)
    );

    assign last_plane = (idx_q == '0);
    assign is_zero    = (sym.kind == SYM_ZERO);
    assign step       = (state_q == PACK_PLANES) && planes_valid_i && (!valid_o || ready_i);
    assign emit       = !is_zero || last_plane;
    assign release_o  = step && last_plane;
    assign run_len    = is_zero ? run_q + 5'd1 : run_q;

    // ------------------------------------------------------------------
    // word builder: header, pending run, plane code
    // ------------------------------------------------------------------
    always_comb begin
        word_d     = '0;
        word_d.sop = first_q;
        word_d.eop = last_plane;
        if (first_q) begin
            word_d.data[CODE_W-1 -: HDR_W] = {HDR_PFX, base_i};
            word_d.size                    = HDR_W;
        end
        if (run_len == 5'd1) begin
            word_d.data |= place({RUN1_CODE, 61'b0}, word_d.size);
            word_d.size += RUN1_W;
        end else if (run_len > 5'd1) begin
            word_d.data |= place({RUNN_PFX, 4'(run_len - 5'd2), 58'b0}, word_d.size);
            word_d.size += RUNN_W;
        end
        if (!is_zero) begin
            word_d.data |= place(sym.code, word_d.size);
            word_d.size += sym.size;
        end
    end

    // ------------------------------------------------------------------
    // plane sequencer and output register
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= PACK_IDLE;
            idx_q   <= '0;
            run_q   <= '0;
            first_q <= 1'b0;
            valid_o <= 1'b0;
            code_o  <= '0;
        end else begin
            if (valid_o && ready_i) begin
                valid_o <= 1'b0;
            end
            case (state_q)
                PACK_IDLE: begin
                    if (planes_valid_i) begin
                        state_q <= PACK_PLANES;
                        idx_q   <= plane_idx_t'(WORD_W - 1);
                        run_q   <= '0;
                        first_q <= 1'b1;
                    end
                end
                PACK_PLANES: begin
                    if (step) begin
                        idx_q <= idx_q - 1'b1;
                        run_q <= emit ? 5'd0 : run_len;
                        if (emit) begin
                            valid_o <= 1'b1;
                            code_o  <= word_d;
                            first_q <= 1'b0;
                        end
                        // block done, wait for the next plane set
                        if (last_plane) begin
                            state_q <= PACK_IDLE;
                        end
                    end
                end
                default: state_q <= PACK_IDLE;
            endcase
        end
    end

endmodule

// ==== hw/bpc_plane_coder.sv ====
// bpc_plane_coder
// classifies one dbx/dbp plane pair into a left-aligned plane code

module bpc_plane_coder
    import bpc_geom_pkg::*;
    import bpc_code_pkg::*;
#(
    parameter int BLOCK_BEATS = 16,
    localparam int NDELTA = WORDS_PER_BEAT * BLOCK_BEATS - 1
) (
    input  logic [NDELTA-1:0] dbx_i,
    input  logic [NDELTA-1:0] dbp_i,
    output symbol_t           sym_o
);

    logic [POS_W:0]   ones;
    logic [POS_W-1:0] low_pos;
    logic             adjacent;

    assign ones     = (POS_W + 1)'($countones(dbx_i));
    assign adjacent = |(dbx_i & (dbx_i >> 1));

    // lowest set bit, also the lower bit of a pair
    always_comb begin
        low_pos = '0;
        for (int i = NDELTA - 1; i >= 0; i--) begin
            if (dbx_i[i]) begin
                low_pos = POS_W'(i);
            end
        end
    end

    always_comb begin
        sym_o = '0;
        if (dbx_i == '0) begin
            sym_o.kind = SYM_ZERO;
        end else if (&dbx_i) begin
            sym_o.kind             = SYM_ONES;
            sym_o.size             = PFX_W;
            sym_o.code[63 -: 5]    = ONES_PFX;
        end else if (dbp_i == '0) begin
            sym_o.kind             = SYM_DBPZ;
            sym_o.size             = PFX_W;
            sym_o.code[63 -: 5]    = DBPZ_PFX;
        end else if (ones == 2 && adjacent) begin
            sym_o.kind              = SYM_PAIR;
            sym_o.size              = PFX_W + code_size_t'(POS_W);
            sym_o.code[63 -: 5]     = PAIR_PFX;
            sym_o.code[58 -: POS_W] = low_pos;
        end else if (ones == 1) begin
            sym_o.kind              = SYM_SINGLE;
            sym_o.size              = PFX_W + code_size_t'(POS_W);
            sym_o.code[63 -: 5]     = SINGLE_PFX;
            sym_o.code[58 -: POS_W] = low_pos;
        end else begin
            sym_o.kind               = SYM_RAW;
            sym_o.size               = code_size_t'(NDELTA + 1);
            sym_o.code[63]           = RAW_PFX;
            sym_o.code[62 -: NDELTA] = dbx_i;
        end
    end

endmodule

// ==== hw/bpc_plane_xform.sv ====
// bpc_plane_xform
// transposes the block deltas into dbp planes and xors them into dbx planes
// holds both plane sets until the packer releases them

module bpc_plane_xform
    import bpc_geom_pkg::*;
#(
    parameter int BLOCK_BEATS = 16,
    localparam int NDELTA = WORDS_PER_BEAT * BLOCK_BEATS - 1
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            block_valid_i,
    output logic                            block_ready_o,
    input  word_t                           base_i,
    input  word_t [NDELTA-1:0]              deltas_i,
    output logic                            planes_valid_o,
    input  logic                            release_i,
    output word_t                           base_o,
    output logic [WORD_W-1:0][NDELTA-1:0]   dbp_o,
    output logic [WORD_W-1:0][NDELTA-1:0]   dbx_o
);

    logic [WORD_W-1:0][NDELTA-1:0] dbp_d;
    logic [WORD_W-1:0][NDELTA-1:0] dbx_d;
    logic                          load;

    assign block_ready_o = ~planes_valid_o | release_i;
    assign load          = block_valid_i & block_ready_o;

    // bit k of plane p is bit p of delta k
    always_comb begin
        for (int p = 0; p < WORD_W; p++) begin
            for (int k = 0; k < NDELTA; k++) begin
                dbp_d[p][k] = deltas_i[k][p];
            end
        end
        dbx_d[WORD_W-1] = dbp_d[WORD_W-1];
        for (int p = 0; p < WORD_W - 1; p++) begin
            dbx_d[p] = dbp_d[p] ^ dbp_d[p+1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            planes_valid_o <= 1'b0;
        end else if (load) begin
            planes_valid_o <= 1'b1;
        end else if (release_i) begin
            planes_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            base_o <= base_i;
            dbp_o  <= dbp_d;
            dbx_o  <= dbx_d;
        end
    end

endmodule

// ==== hw/bpc_delta_collect.sv ====
// bpc_delta_collect
// beat intake, base word capture and delta computation
// holds a complete block until the plane transform takes it

module bpc_delta_collect
    import bpc_geom_pkg::*;
#(
    parameter int BLOCK_BEATS = 16,
    localparam int NDELTA = WORDS_PER_BEAT * BLOCK_BEATS - 1
) (
    input  logic               clk,
    input  logic               rst_n,
    input  beat_t              beat_i,
    input  logic               valid_i,
    output logic               ready_o,
    output logic               block_valid_o,
    input  logic               block_ready_i,
    output word_t              base_o,
    output word_t [NDELTA-1:0] deltas_o
);

    localparam int CNT_W = $clog2(BLOCK_BEATS);

    logic [CNT_W-1:0]            bcnt_q;
    word_t                       last_q;
    word_t [0:WORDS_PER_BEAT-1]  words;
    word_t [0:WORDS_PER_BEAT-1]  diff;
    logic                        accept;
    logic                        last_beat;

    // words[0] is the top word of the beat
    assign words     = beat_i;
    assign ready_o   = ~block_valid_o;
    assign accept    = valid_i & ready_o;
    assign last_beat = (bcnt_q == CNT_W'(BLOCK_BEATS - 1));

    // slot 0 is the cross-beat delta
    always_comb begin
        diff[0] = words[0] - last_q;
        for (int p = 1; p < WORDS_PER_BEAT; p++) begin
            diff[p] = words[p] - words[p-1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bcnt_q        <= '0;
            block_valid_o <= 1'b0;
        end else begin
            if (block_valid_o && block_ready_i) begin
                block_valid_o <= 1'b0;
            end
            if (accept) begin
                bcnt_q <= last_beat ? '0 : bcnt_q + 1'b1;
                if (last_beat) begin
                    block_valid_o <= 1'b1;
                end
            end
        end
    end

    // delta k belongs to word k+1 of the block
    always_ff @(posedge clk) begin
        if (accept) begin
            last_q <= words[WORDS_PER_BEAT-1];
            if (bcnt_q == '0) begin
                base_o <= words[0];
            end
            for (int k = 0; k < NDELTA; k++) begin
                if (bcnt_q == CNT_W'((k + 1) / WORDS_PER_BEAT)) begin
                    deltas_o[k] <= diff[(k + 1) % WORDS_PER_BEAT];
                end
            end
        end
    end

endmodule

// ==== hw/bpc_code_pkg.sv ====
// code prefixes, field sizes and symbol kinds
// symbol and output word structs

package bpc_code_pkg;

    // header + longest run code + raw plane
    localparam int CODE_W = 88;

    typedef logic [6:0] code_size_t;

    // ------------------------------------------------------------------
    // prefixes and field sizes
    // ------------------------------------------------------------------
    localparam logic [1:0] HDR_PFX    = 2'b00;
    localparam logic [2:0] RUN1_CODE  = 3'b001;
    localparam logic [1:0] RUNN_PFX   = 2'b01;
    localparam logic [4:0] ONES_PFX   = 5'b00000;
    localparam logic [4:0] DBPZ_PFX   = 5'b00001;
    localparam logic [4:0] PAIR_PFX   = 5'b00010;
    localparam logic [4:0] SINGLE_PFX = 5'b00011;
    localparam logic       RAW_PFX    = 1'b1;

    localparam code_size_t HDR_W  = 7'd18;
    localparam code_size_t RUN1_W = 7'd3;
    localparam code_size_t RUNN_W = 7'd6;
    localparam code_size_t PFX_W  = 7'd5;

    // ------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------
    typedef enum logic [2:0] {
        SYM_ZERO,
        SYM_ONES,
        SYM_DBPZ,
        SYM_PAIR,
        SYM_SINGLE,
        SYM_RAW
    } sym_kind_e;

    // code is left aligned, zero below size
    typedef struct packed {
        sym_kind_e   kind;
        code_size_t  size;
        logic [63:0] code;
    } symbol_t;

    typedef struct packed {
        logic              sop;
        logic              eop;
        code_size_t        size;
        logic [CODE_W-1:0] data;
    } code_beat_t;

endpackage

// ==== hw/bpc_geom_pkg.sv ====
// block geometry for the bit-plane compression engine
// word, beat and plane index types

package bpc_geom_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    localparam int WORD_W          = 16;
    localparam int WORDS_PER_BEAT  = 4;
    localparam int MAX_BLOCK_BEATS = 16;

    // enough for a bit index inside a 63-bit plane
    localparam int POS_W = 6;

    // ------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------
    typedef logic [WORD_W-1:0] word_t;

    // first word of the beat in the top 16 bits
    typedef logic [WORDS_PER_BEAT*WORD_W-1:0] beat_t;

    // plane 15 is the msb plane
    typedef logic [3:0] plane_idx_t;

endpackage
